// File: logic/mem_pkg.sv
package mem_pkg;

    // word geometry seen by the requester
    localparam int DATA_W = 32;                 // one data word
    localparam int ADDR_W = 10;                 // word address

    // plain vectors for the widths that carry a meaning
    typedef logic [DATA_W-1:0] data_t;          // write data, write mask, read data
    typedef logic [ADDR_W-1:0] addr_t;          // word address

    // request opcode, one bit on the wire
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // one request as carried from the requester to the memory
    // a wmask bit of 1 means that bit is written
    typedef struct packed {
        mem_op_e op;                            // read or write
        addr_t   addr;                          // word address
        data_t   wmask;                         // per bit write mask
        data_t   wdata;                         // write data
    } mem_req_t;                                // 75 bits

endpackage

// File: logic/sram_macro.sv
`timescale 1ns/10ps

module sram_macro #(
    parameter int AW = 8,
    parameter int DW = 16
) (
    input  logic          clk,
    input  logic          ce_in,
    input  logic          we_in,
    input  logic [AW-1:0] addr_in,
    input  logic [DW-1:0] wd_in,
    input  logic [DW-1:0] w_mask_in,
    output logic [DW-1:0] rd_out
);

    localparam int WORDS = 2 ** AW;

    logic [DW-1:0] mem [WORDS];                     // storage array
    logic [DW-1:0] cur;
    logic          wr_en;
    logic          rd_en;

    assign cur   = mem[addr_in];
    assign wr_en = ce_in && we_in;
    assign rd_en = ce_in && !we_in;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr_in] <= (wd_in & w_mask_in) | (cur & ~w_mask_in);   // bitwise merge
        end
    end

    // read port, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_out <= cur;
        end
    end

endmodule

// File: logic/la_spram.sv
`timescale 1ns/10ps

module la_spram #(
    parameter int MACRO_AW = 8,
    parameter int MACRO_DW = 16
) (
    input  logic           clk,
    input  logic           ce,
    input  logic           we,
    input  mem_pkg::data_t wmask,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::data_t din,
    output mem_pkg::data_t dout
);
    import mem_pkg::*;

    localparam int ROWS  = (ADDR_W > MACRO_AW) ? 2 ** (ADDR_W - MACRO_AW) : 1;
    localparam int ROW_W = (ADDR_W > MACRO_AW) ? ADDR_W - MACRO_AW : 1;
    localparam int COLS  = (DATA_W + MACRO_DW - 1) / MACRO_DW;
    localparam int PAD_W = COLS * MACRO_DW;

    logic [MACRO_AW-1:0] macro_addr;                // shared by every tile
    logic [PAD_W-1:0]    din_pad;
    logic [PAD_W-1:0]    wmask_pad;
    data_t               row_dout [ROWS];

    assign macro_addr = MACRO_AW'(addr);            // low bits address inside a macro
    assign din_pad    = PAD_W'(din);                // unused macro bits stay zero
    assign wmask_pad  = PAD_W'(wmask);

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        logic             selected;
        logic             sel_q;                    // row owning the last read
        logic             row_ce;
        logic             row_we;
        logic [PAD_W-1:0] row_rd;

        if (ROWS == 1) begin : g_one
            assign selected = 1'b1;
        end else begin : g_dec
            assign selected = (addr[ADDR_W-1:MACRO_AW] == ROW_W'(r));
        end

        assign row_ce = ce && selected;
        assign row_we = we && selected;

        always_ff @(posedge clk) begin
            if (ce && !we) begin
                sel_q <= selected;                  // follows the registered read data
            end
        end

        for (genvar c = 0; c < COLS; c++) begin : g_col
            sram_macro #(
                .AW(MACRO_AW),
                .DW(MACRO_DW)
            ) u_macro (
                .clk      (clk),
                .ce_in    (row_ce),
                .we_in    (row_we),
                .addr_in  (macro_addr),
                .wd_in    (din_pad[c*MACRO_DW +: MACRO_DW]),
                .w_mask_in(wmask_pad[c*MACRO_DW +: MACRO_DW]),
                .rd_out   (row_rd[c*MACRO_DW +: MACRO_DW])
            );
        end

        assign row_dout[r] = sel_q ? DATA_W'(row_rd) : '0;
    end

    // only the selected row drives non-zero bits
    always_comb begin
        dout = '0;
        for (int r = 0; r < ROWS; r++) begin
            dout = dout | row_dout[r];
        end
    end

endmodule

// File: logic/req_fifo.sv
`timescale 1ns/10ps

module req_fifo #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  mem_pkg::mem_req_t push_req,
    input  logic              pop,
    output mem_pkg::mem_req_t head,
    output logic              not_empty
);
    import mem_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    mem_req_t      slots [DEPTH];               // payload storage
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;                       // occupancy, bounded by credits

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // wrap for any depth
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // idle or push and pop together
            endcase
        end
    end

    assign head      = slots[rd_ptr];               // visible the cycle after push
    assign not_empty = (count != '0);

endmodule

// File: logic/mem_ctrl.sv
`timescale 1ns/10ps

module mem_ctrl #(
    parameter int FIFO_DEPTH  = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t head,
    input  logic              not_empty,
    input  logic              rsp_credit,
    output logic              pop,
    output logic              ram_ce,
    output logic              ram_we,
    output logic              req_credit,
    output logic              rsp_valid
);
    import mem_pkg::*;

    localparam int GW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(RSP_CREDITS + 1);

    typedef enum logic {
        ST_GRANT,                                   // hand out the initial ingress credits
        ST_RUN                                      // issue requests from the buffer
    } state_e;

    state_e        state;
    logic [GW-1:0] grant_cnt;                       // initial credits granted so far
    logic [CW-1:0] rsp_cnt;                         // response credits on hand
    logic          is_read;
    logic          can_issue;
    logic          rd_issue;

    assign is_read   = (head.op == OP_READ);
    assign can_issue = !is_read || (rsp_cnt != '0); // writes ignore response credits

    // issue on the same cycle the head is valid
    assign pop      = (state == ST_RUN) && not_empty && can_issue;
    assign ram_ce   = pop;
    assign ram_we   = pop && !is_read;
    assign rd_issue = pop && is_read;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_GRANT;
            grant_cnt  <= '0;
            req_credit <= 1'b0;
        end else begin
            case (state)
                ST_GRANT: begin
                    req_credit <= 1'b1;             // one pulse per cycle
                    grant_cnt  <= grant_cnt + 1'b1;
                    if (grant_cnt == GW'(FIFO_DEPTH - 1)) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    req_credit <= pop;              // slot freed, return it next cycle
                end
                default: begin
                    state      <= ST_GRANT;
                    req_credit <= 1'b0;
                end
            endcase
        end
    end

    // response side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_cnt   <= CW'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_issue;                  // lines up with registered dout
            case ({rd_issue, rsp_credit})
                2'b10:   rsp_cnt <= rsp_cnt - 1'b1;
                2'b01:   rsp_cnt <= rsp_cnt + 1'b1;
                default: rsp_cnt <= rsp_cnt;        // spend and return cancel out
            endcase
        end
    end

endmodule

// File: logic/mem_subsys.sv
`timescale 1ns/10ps

module mem_subsys #(
    parameter int FIFO_DEPTH  = 4,
    parameter int RSP_CREDITS = 2,
    parameter int MACRO_AW    = 8,
    parameter int MACRO_DW    = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  mem_pkg::mem_req_t req,
    output logic              req_credit,
    output logic              rsp_valid,
    output mem_pkg::data_t    rsp_data,
    input  logic              rsp_credit
);
    import mem_pkg::*;

    mem_req_t head;                                 // oldest buffered request
    logic     not_empty;
    logic     pop;
    logic     ram_ce;
    logic     ram_we;

    req_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (req_valid),                      // credits keep it from overflowing
        .push_req (req),
        .pop      (pop),
        .head     (head),
        .not_empty(not_empty)
    );

    mem_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .RSP_CREDITS(RSP_CREDITS)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .not_empty (not_empty),
        .rsp_credit(rsp_credit),
        .pop       (pop),
        .ram_ce    (ram_ce),
        .ram_we    (ram_we),
        .req_credit(req_credit),
        .rsp_valid (rsp_valid)
    );

    la_spram #(
        .MACRO_AW(MACRO_AW),
        .MACRO_DW(MACRO_DW)
    ) u_ram (
        .clk  (clk),
        .ce   (ram_ce),
        .we   (ram_we),
        .wmask(head.wmask),
        .addr (head.addr),
        .din  (head.wdata),
        .dout (rsp_data)                            // valid with rsp_valid
    );

endmodule

// File: verif/mem_subsys_chk.sv
`timescale 1ns/10ps

module mem_subsys_chk #(
    parameter int RSP_CREDITS = 2
) (
    input logic clk,
    input logic rst_n,
    input logic ram_ce,
    input logic ram_we,
    input logic rsp_valid,
    input logic rsp_credit
);

    logic rd_issue;
    int   rsp_cnt;                                  // shadow of the response credits

    assign rd_issue = ram_ce && !ram_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_cnt <= RSP_CREDITS;
        end else begin
            rsp_cnt <= rsp_cnt - (rd_issue ? 1 : 0) + (rsp_credit ? 1 : 0);
        end
    end

    a_rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(rd_issue))
        else $error("rsp_valid without a read issued the cycle before");

    a_we_with_ce: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> ram_ce)
        else $error("ram_we high while ram_ce is low");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_cnt <= RSP_CREDITS)
        else $error("response credit count above RSP_CREDITS");

    // back-pressure, no read while the receiver holds every credit
    a_read_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        rd_issue |-> (rsp_cnt > 0))
        else $error("read issued with no response credit left");

endmodule

bind mem_subsys mem_subsys_chk #(
    .RSP_CREDITS(RSP_CREDITS)
) u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .ram_ce    (ram_ce),
    .ram_we    (ram_we),
    .rsp_valid (rsp_valid),
    .rsp_credit(rsp_credit)
);

// File: verif/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int FIFO_DEPTH      = 4;
    localparam int RSP_CREDITS     = 2;
    localparam int MACRO_AW        = 8;
    localparam int MACRO_DW        = 16;
    localparam int PERIOD          = 100;           // ns
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_LINE = 20;            // timeout margin per data line
    localparam int MAX_LINES       = 64;
    localparam int COLS            = 7;             // test hold op addr wmask wdata expect
    localparam int HOLD_CYCLES     = 20;            // window with response credits held
    localparam int DRAIN_LIMIT     = 100;
    localparam int SEED            = 32'h76aa7d79;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    mem_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    data_t    rsp_data;
    logic     rsp_credit;

    logic [31:0] td [MAX_LINES * COLS];             // raw testdata words
    data_t       exp_q [$];                         // read data still to come back
    int          n_lines;
    int          cycles;
    int          cycle_limit;
    int          credits_in;                        // req_credit pulses seen
    int          credits_used;                      // requests sent
    int          rsp_count;
    int          owed;                              // response credits not yet returned
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    bit          hold_rsp;

    mem_subsys #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .RSP_CREDITS(RSP_CREDITS),
        .MACRO_AW   (MACRO_AW),
        .MACRO_DW   (MACRO_DW)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_credit(req_credit),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_credit(rsp_credit)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n && req_credit) begin
            credits_in++;                           // one credit per pulse
        end
    end

    always @(posedge clk) begin : rsp_monitor
        data_t want;
        if (rst_n && rsp_valid) begin
            rsp_count++;
            owed++;
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived at %0t with no read outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                if (rsp_data !== want) begin
                    errors++;
                    $display("mismatch at %0t: read data %h, expected %h",
                             $time, rsp_data, want);
                end
            end
        end
    end

    // receiver hands response credits back after a random delay
    initial begin : credit_return
        int delay;
        rsp_credit = 1'b0;
        delay = $urandom(SEED);
        forever begin
            @(posedge clk);
            #1;
            if (owed > 0 && !hold_rsp) begin
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                rsp_credit = 1'b1;
                owed--;
                @(posedge clk);
                #1;
                rsp_credit = 1'b0;
            end
        end
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "initial credit grant";
            2:       return "write then read";
            3:       return "masked write merge";
            4:       return "tile independence";
            5:       return "response back-pressure";
            6:       return "full credit burst";
            default: return "data test";
        endcase
    endfunction

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    // called 1 ns after an edge, leaves 1 ns after the next one
    task automatic send_line(input int idx);
        int base;
        base = idx * COLS;
        while (credits_in - credits_used == 0) begin
            tick();
        end
        req.op    = mem_op_e'(td[base + 2][0]);
        req.addr  = addr_t'(td[base + 3]);
        req.wmask = td[base + 4];
        req.wdata = td[base + 5];
        req_valid = 1'b1;
        credits_used++;
        if (td[base + 2][0] == 1'b0) begin
            exp_q.push_back(td[base + 6]);
        end
        tick();
        req_valid = 1'b0;
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed != 0 ||
                credits_in - credits_used != FIFO_DEPTH) && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        repeat (2) tick();                          // last returned credit lands
    endtask

    task automatic finish_test(input int id, input int err_before);
        checks++;
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads of test %0d never returned data", exp_q.size(), id);
            exp_q.delete();
        end
        if (credits_in - credits_used != FIFO_DEPTH) begin
            errors++;
            $display("mismatch at %0t: requester holds %0d credits, expected %0d",
                     $time, credits_in - credits_used, FIFO_DEPTH);
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", id, test_name(id),
                     errors - err_before);
        end
    endtask

    initial begin
        int idx;
        int id;
        int hold;
        int reads;
        int start_rsp;
        int seen;
        int expect_seen;
        int err_before;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        hold_rsp     = 1'b0;
        cycles       = 0;
        credits_in   = 0;
        credits_used = 0;
        rsp_count    = 0;
        owed         = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        $readmemh("verif/mem_testdata.txt", td);
        n_lines = -1;
        for (int i = 0; i < MAX_LINES && n_lines < 0; i++) begin
            if (td[i * COLS] == 32'd0) begin
                n_lines = i;                        // end marker
            end
        end
        if (n_lines <= 0) begin
            errors++;
            $display("the testdata file holds no usable lines or lacks its end marker");
            n_lines = 0;
        end
        cycle_limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // nothing is sent until the grant is complete
        err_before = errors;
        repeat (FIFO_DEPTH + 8) tick();
        finish_test(1, err_before);

        idx = 0;
        while (idx < n_lines) begin
            id         = int'(td[idx * COLS]);
            hold       = int'(td[idx * COLS + 1]);
            err_before = errors;
            start_rsp  = rsp_count;
            reads      = 0;
            hold_rsp   = (hold != 0);
            while (idx < n_lines && int'(td[idx * COLS]) == id) begin
                if (td[idx * COLS + 2][0] == 1'b0) begin
                    reads++;
                end
                send_line(idx);
                idx++;
            end
            if (hold != 0) begin
                repeat (HOLD_CYCLES) tick();
                checks++;
                seen        = rsp_count - start_rsp;
                expect_seen = (reads < RSP_CREDITS) ? reads : RSP_CREDITS;
                if (seen != expect_seen) begin
                    errors++;
                    $display("mismatch at %0t: %0d responses while credits held, expected %0d",
                             $time, seen, expect_seen);
                end
                hold_rsp = 1'b0;                    // release, the rest follow in order
            end
            drain();
            finish_test(id, err_before);
        end

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verif/mem_testdata.txt
// columns in hex: test hold op addr wmask wdata expect (op 1 write, 0 read)
// lines with the same test number form one test, hold 1 keeps response credits back
2 0 1 005 FFFFFFFF DEADBEEF 00000000
2 0 0 005 00000000 00000000 DEADBEEF
2 0 1 0C3 FFFFFFFF 12345678 00000000
2 0 0 0C3 00000000 00000000 12345678
3 0 1 010 FFFFFFFF A5A5A5A5 00000000
3 0 1 010 0000FFFF 12345678 00000000
3 0 0 010 00000000 00000000 A5A55678
3 0 1 010 F0F00F0F CAFEBABE 00000000
3 0 0 010 00000000 00000000 C5F55A7E
4 0 1 020 FFFFFFFF 11112222 00000000
4 0 1 120 FFFFFFFF 33334444 00000000
4 0 1 220 FFFFFFFF 55556666 00000000
4 0 1 320 FFFFFFFF 77778888 00000000
4 0 1 120 FFFF0000 ABCD0000 00000000
4 0 1 220 0000FFFF 0000BEEF 00000000
4 0 0 020 00000000 00000000 11112222
4 0 0 120 00000000 00000000 ABCD4444
4 0 0 220 00000000 00000000 5555BEEF
4 0 0 320 00000000 00000000 77778888
5 1 0 005 00000000 00000000 DEADBEEF
5 1 0 0C3 00000000 00000000 12345678
5 1 0 010 00000000 00000000 C5F55A7E
5 1 0 120 00000000 00000000 ABCD4444
5 1 0 320 00000000 00000000 77778888
6 0 1 040 FFFFFFFF 0BADF00D 00000000
6 0 1 141 FFFFFFFF FEEDFACE 00000000
6 0 1 242 FFFFFFFF 13579BDF 00000000
6 0 1 343 FFFFFFFF 2468ACE0 00000000
6 0 1 0FF FFFFFFFF 5A5AA5A5 00000000
6 0 0 040 00000000 00000000 0BADF00D
6 0 0 141 00000000 00000000 FEEDFACE
6 0 0 242 00000000 00000000 13579BDF
6 0 0 343 00000000 00000000 2468ACE0
6 0 0 0FF 00000000 00000000 5A5AA5A5
0 0 0 000 00000000 00000000 00000000

// File: verilog.f
logic/mem_pkg.sv
logic/sram_macro.sv
logic/la_spram.sv
logic/req_fifo.sv
logic/mem_ctrl.sv
logic/mem_subsys.sv
verif/mem_subsys_chk.sv
verif/mem_subsys_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_subsys_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
